// ==== sim.f ====
source/fb_pkg.sv
source/raster_timer.sv
source/buffer_arbiter.sv
source/frame_store.sv
source/scan_out.sv
source/framebuffer_top.sv
testbench/tb_framebuffer.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_framebuffer
FILELIST  = sim.f

BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = All checks passed

.PHONY: all lint sim clean

all: sim

# Static checks of design and testbench
lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

# Build, run, then decide pass or fail from the log
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== testbench/tb_framebuffer.sv ====
module tb_framebuffer;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS    = 10;
    localparam int RESET_CYC = 5;
    localparam int SRC_W     = 4;
    localparam int SRC_H     = 3;
    localparam int SCALE     = 2;
    localparam int NPIX      = SRC_W * SRC_H;

    // Tiny raster so a whole frame is only a couple of hundred clocks
    localparam fb_pkg::timing_t TB_TIMING = '{
        h_active: 11'd11, h_sync_start: 11'd12, h_sync_end: 11'd14, h_total: 11'd16,
        v_active: 11'd7,  v_sync_start: 11'd8,  v_sync_end: 11'd9,  v_total: 11'd10
    };
    localparam int H_ACT     = int'(TB_TIMING.h_active);
    localparam int H_SW      = int'(TB_TIMING.h_sync_end) - int'(TB_TIMING.h_sync_start);
    localparam int H_TOT     = int'(TB_TIMING.h_total);
    localparam int V_ACT     = int'(TB_TIMING.v_active);
    localparam int V_SS      = int'(TB_TIMING.v_sync_start);
    localparam int V_SW      = int'(TB_TIMING.v_sync_end) - V_SS;
    localparam int V_TOT     = int'(TB_TIMING.v_total);
    localparam int WIN_X0    = (H_ACT + 1 - SRC_W * SCALE) / 2;    // Centred window origin
    localparam int WIN_Y0    = (V_ACT + 1 - SRC_H * SCALE) / 2;
    localparam int FRAME_CYC = (H_TOT + 1) * (V_TOT + 1);
    // Frames spent by the five tests, 3 + 3 + 4 + 6 + 4
    localparam int RUN_FRAMES  = 20;
    localparam int WATCHDOG_NS = 2 * (RESET_CYC + RUN_FRAMES * FRAME_CYC) * CLK_NS;
    localparam int EV_LINE   = 0;                                   // Monitor event kinds
    localparam int EV_FRAME  = 1;
    localparam int EV_DONE   = 2;

    logic              clk_vga;
    logic              rst_n;
    logic              pix_valid;
    fb_pkg::wr_pixel_t pix;
    logic              vblank_in;
    logic              disable_db;
    fb_pkg::pixel_t    rgb_out;
    logic              hsync_out;
    logic              vsync_out;
    logic              blank_out;
    logic              odd_line_out;
    logic              buffer_using;

    logic [15:0]    lfsr;
    fb_pkg::pixel_t model [5][NPIX];            // Source frames as written
    fb_pkg::pixel_t scr [V_ACT + 1][H_ACT + 1]; // Output frame being captured
    fb_pkg::pixel_t cap [V_ACT + 1][H_ACT + 1]; // Last complete output frame
    int errors;
    int checks;
    int tests_run;
    int tests_failed;
    // Monitor state, updated on the falling edge only
    int   out_col;
    int   out_line;
    int   hs_age;
    int   hs_period;
    int   hs_low;
    int   hs_width;
    int   act_run;
    int   act_len;
    int   vs_low;
    int   vs_width;
    int   line_q;
    int   hs_falls;
    int   fstart_cnt;
    int   fdone_cnt;
    int   using_toggles;
    logic synced;
    logic prev_bl;
    logic prev_hs;
    logic prev_vs;
    logic prev_using;
    logic odd_q;
    logic using_q;

    framebuffer_top #(.SRC_W(SRC_W), .SRC_H(SRC_H), .SCALE(SCALE), .TIMING(TB_TIMING)) dut0 (
        .clk_vga(clk_vga), .rst_n(rst_n), .pix_valid(pix_valid), .pix(pix),
        .vblank_in(vblank_in), .disable_db(disable_db), .rgb_out(rgb_out),
        .hsync_out(hsync_out), .vsync_out(vsync_out), .blank_out(blank_out),
        .odd_line_out(odd_line_out), .buffer_using(buffer_using)
    );

    always #(CLK_NS / 2) clk_vga = ~clk_vga;

    // ------------------------------------------------------------------------
    // Output monitor
    // ------------------------------------------------------------------------

    always @(negedge clk_vga) begin
        if (!rst_n) begin
            synced     = 1'b0;
            out_col    = 0;
            out_line   = 0;
            hs_age     = 0;
            hs_low     = 0;
            act_run    = 0;
            vs_low     = 0;
            prev_bl    = 1'b0;
            prev_hs    = 1'b1;
            prev_vs    = 1'b1;
            prev_using = buffer_using;
        end else begin
            // Column locks to the end of the active part of each line
            if (blank_out && !prev_bl)
                out_col = H_ACT + 1;
            else
                out_col = (out_col == H_TOT) ? 0 : out_col + 1;
            if (out_col == 0)
                out_line = (out_line == V_TOT) ? 0 : out_line + 1;
            if (!vsync_out && prev_vs) begin
                out_line = V_SS + 1;                // First line of the sync pulse
                synced   = 1'b1;
            end
            if (synced && out_line <= V_ACT && out_col <= H_ACT)
                scr[out_line][out_col] = rgb_out;
            if (synced && out_line == V_ACT && out_col == H_ACT) begin
                cap = scr;                          // Visible area complete
                fdone_cnt++;
            end
            if (synced && out_line == 0 && out_col == 0)
                fstart_cnt++;
            hs_age++;
            if (!hsync_out && prev_hs) begin        // Line marker
                hs_period = hs_age;
                hs_age    = 0;
                odd_q     = odd_line_out;
                line_q    = out_line;
                hs_falls++;
            end
            if (!hsync_out) begin
                hs_low++;
            end else if (!prev_hs) begin
                hs_width = hs_low;
                hs_low   = 0;
            end
            if (!blank_out) begin
                act_run++;
            end else if (!prev_bl) begin
                act_len = act_run;
                act_run = 0;
            end
            if (!vsync_out) begin
                vs_low++;
            end else if (!prev_vs) begin
                vs_width = vs_low;
                vs_low   = 0;
            end
            if (buffer_using != prev_using)
                using_toggles++;
            prev_bl    = blank_out;
            prev_hs    = hsync_out;
            prev_vs    = vsync_out;
            prev_using = buffer_using;
        end
        using_q = buffer_using;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // Taps 16 14 13 11
    endfunction

    task automatic fill_model(input int fid);
        fb_pkg::pixel_t p;
        for (int i = 0; i < NPIX; i++) begin
            for (int b = 0; b < fb_pkg::PIXEL_W; b++) begin
                lfsr = lfsr_step(lfsr);             // One step per bit
                p = {p[fb_pkg::PIXEL_W-2:0], lfsr[0]};
            end
            model[fid][i] = p;
        end
    endtask

    // Black outside the scaled picture
    function automatic fb_pkg::pixel_t expected_pixel(input int fid, input int l, input int c);
        if (c < WIN_X0 || c >= WIN_X0 + SRC_W * SCALE) return '0;
        if (l < WIN_Y0 || l >= WIN_Y0 + SRC_H * SCALE) return '0;
        return model[fid][((l - WIN_Y0) / SCALE) * SRC_W + (c - WIN_X0) / SCALE];
    endfunction

    function automatic int event_count(input int kind);
        case (kind)
            EV_LINE:  return hs_falls;
            EV_FRAME: return fstart_cnt;
            default:  return fdone_cnt;
        endcase
    endfunction

    task automatic compare(input string name, input int got, input int exp);
        checks++;
        assert (got == exp) else begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // Returns on the rising edge after the monitor saw the event
    task automatic wait_event(input int kind, input string what);
        int n0;
        int t;
        n0 = event_count(kind);
        t  = 0;
        while (event_count(kind) == n0 && t < 2 * FRAME_CYC) begin
            @(posedge clk_vga);
            t++;
        end
        checks++;
        assert (event_count(kind) != n0) else begin
            $display("Timed out after %0d cycles waiting for %s", t, what);
            errors++;
        end
    endtask

    task automatic verify_screen(input int fid);
        fb_pkg::pixel_t exp;
        for (int l = 0; l <= V_ACT; l++) begin
            for (int c = 0; c <= H_ACT; c++) begin
                exp = expected_pixel(fid, l, c);
                checks++;
                assert (cap[l][c] === exp) else begin
                    $display("Error: rgb_out line %0d col %0d got 0x%0h expected 0x%0h",
                             l, c, cap[l][c], exp);
                    errors++;
                end
            end
        end
    endtask

    task automatic next_full_frame(input int fid);
        wait_event(EV_FRAME, "output frame start");
        wait_event(EV_DONE, "output frame end");
        verify_screen(fid);
    endtask

    task automatic open_frame();
        @(negedge clk_vga);
        vblank_in = 1'b0;                           // Arbiter acts one clock later
    endtask

    task automatic close_frame();
        @(negedge clk_vga);
        vblank_in = 1'b1;
        @(negedge clk_vga);                         // Let the arbiter see the edge
    endtask

    task automatic strobe_pixels(input int fid, input int first, input int last);
        for (int i = first; i <= last; i++) begin
            @(negedge clk_vga);
            pix_valid = 1'b1;
            pix.x     = 10'(i % SRC_W);             // Row major order
            pix.y     = 10'(i / SRC_W);
            pix.rgb   = model[fid][i];
        end
        @(negedge clk_vga);
        pix_valid = 1'b0;
    endtask

    task automatic write_frame(input int fid);
        fill_model(fid);
        open_frame();
        strobe_pixels(fid, 0, NPIX - 1);
        close_frame();
    endtask

    task automatic report_test(input string name, input int e0);
        tests_run++;
        if (errors == e0) begin
            $display("test %s: pass", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", name, errors - e0);
        end
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------

    task automatic raster_timing();
        int   e0;
        logic last_odd;
        e0 = errors;
        wait_event(EV_FRAME, "first locked output frame");
        for (int i = 0; i <= V_TOT; i++) begin
            wait_event(EV_LINE, "hsync_out falling edge");
            compare("hsync_out period", hs_period, H_TOT + 1);
            compare("hsync_out width", hs_width, H_SW);
            compare("odd_line_out", int'(odd_q), line_q % 2);
            if (line_q <= V_ACT) compare("blank_out low cycles", act_len, H_ACT + 1);
            if (line_q > 0) compare("odd_line_out toggle", int'(odd_q ^ last_odd), 1);
            last_odd = odd_q;
        end
        compare("vsync_out width", vs_width, V_SW * (H_TOT + 1));
        report_test("raster", e0);
    endtask

    task automatic single_buffer();
        int e0;
        e0 = errors;
        @(negedge clk_vga);
        disable_db = 1'b1;
        write_frame(0);                             // Lands in the shown buffer
        next_full_frame(0);
        report_test("single buffer", e0);
    endtask

    task automatic double_buffer();
        int e0;
        int t0;
        e0 = errors;
        @(negedge clk_vga);
        disable_db = 1'b0;
        t0 = using_toggles;
        wait_event(EV_FRAME, "output frame start");
        write_frame(1);
        wait_event(EV_DONE, "output frame end");
        verify_screen(0);                           // Old picture until frame_end
        compare("buffer_using", int'(using_q), 0);
        next_full_frame(1);
        next_full_frame(1);
        compare("buffer_using", int'(using_q), 1);
        compare("buffer_using toggles", using_toggles - t0, 1);
        report_test("double buffer", e0);
    endtask

    task automatic partial_frame();
        int e0;
        int t0;
        e0 = errors;
        t0 = using_toggles;
        fill_model(2);
        wait_event(EV_FRAME, "output frame start");
        open_frame();
        strobe_pixels(2, 0, NPIX / 2 - 1);          // Half a frame, vblank_in stays low
        next_full_frame(1);
        next_full_frame(1);
        compare("buffer_using toggles", using_toggles - t0, 0);
        wait_event(EV_FRAME, "output frame start");
        strobe_pixels(2, NPIX / 2, NPIX - 1);
        close_frame();
        wait_event(EV_DONE, "output frame end");
        verify_screen(1);
        next_full_frame(2);
        compare("buffer_using toggles", using_toggles - t0, 1);
        report_test("no tearing", e0);
    endtask

    task automatic dropped_frame();
        int e0;
        int t0;
        e0 = errors;
        t0 = using_toggles;
        wait_event(EV_FRAME, "output frame start");
        write_frame(3);                             // Takes the free buffer
        write_frame(4);                             // No free buffer left
        wait_event(EV_DONE, "output frame end");
        verify_screen(2);
        next_full_frame(3);
        next_full_frame(3);
        compare("buffer_using toggles", using_toggles - t0, 1);
        report_test("dropped frame", e0);
    endtask

    initial begin
        clk_vga       = 1'b0;
        rst_n         = 1'b0;
        pix_valid     = 1'b0;
        pix           = '0;
        vblank_in     = 1'b1;
        disable_db    = 1'b0;
        lfsr          = 16'd49;
        errors        = 0;
        checks        = 0;
        tests_run     = 0;
        tests_failed  = 0;
        hs_falls      = 0;
        fstart_cnt    = 0;
        fdone_cnt     = 0;
        using_toggles = 0;
        repeat (RESET_CYC) @(negedge clk_vga);
        rst_n = 1'b1;
        raster_timing();
        single_buffer();
        double_buffer();
        partial_frame();
        dropped_frame();
        $display("%0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Hang guard over twice the expected run length
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired at %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== source/framebuffer_top.sv ====
module framebuffer_top #(
    parameter int              SRC_W  = 320,
    parameter int              SRC_H  = 240,
    parameter int              SCALE  = 2,
    parameter fb_pkg::timing_t TIMING = fb_pkg::VGA_640X480
) (
    input  logic              clk_vga,
    input  logic              rst_n,
    input  logic              pix_valid,       // One clock per pixel, no stall
    input  fb_pkg::wr_pixel_t pix,
    input  logic              vblank_in,       // Source frame framing
    input  logic              disable_db,      // Single buffer mode
    output fb_pkg::pixel_t    rgb_out,
    output logic              hsync_out,
    output logic              vsync_out,
    output logic              blank_out,
    output logic              odd_line_out,
    output logic              buffer_using     // Buffer on screen
);

    localparam int AW = $clog2(SRC_W * SRC_H);

    fb_pkg::raster_t raster;
    fb_pkg::pixel_t  rd_data;
    logic [AW-1:0]   rd_addr;
    logic [1:0]      wr_en;
    logic            show_sel;
    logic            frame_end;

    // Free running display timing
    raster_timer #(.SRC_W(SRC_W), .SRC_H(SRC_H), .SCALE(SCALE), .TIMING(TIMING)) u_raster (
        .clk_vga   (clk_vga),
        .rst_n     (rst_n),
        .raster    (raster),
        .frame_end (frame_end)
    );

    // Double buffer ownership
    buffer_arbiter u_arbiter (
        .clk_vga      (clk_vga),
        .rst_n        (rst_n),
        .pix_valid    (pix_valid),
        .vblank_in    (vblank_in),
        .disable_db   (disable_db),
        .frame_end    (frame_end),
        .wr_en        (wr_en),
        .show_sel     (show_sel),
        .buffer_using (buffer_using)
    );

    frame_store #(.SRC_W(SRC_W), .SRC_H(SRC_H)) u_store (
        .clk_vga  (clk_vga),
        .wr_en    (wr_en),
        .pix      (pix),
        .show_sel (show_sel),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    // Three clock read and output pipeline
    scan_out #(.SRC_W(SRC_W), .SRC_H(SRC_H)) u_scan (
        .clk_vga      (clk_vga),
        .rst_n        (rst_n),
        .raster       (raster),
        .rd_data      (rd_data),
        .rd_addr      (rd_addr),
        .rgb_out      (rgb_out),
        .hsync_out    (hsync_out),
        .vsync_out    (vsync_out),
        .blank_out    (blank_out),
        .odd_line_out (odd_line_out)
    );

endmodule

// ==== source/scan_out.sv ====
module scan_out #(
    parameter int  SRC_W = 320,
    parameter int  SRC_H = 240,
    localparam int AW    = $clog2(SRC_W * SRC_H)
) (
    input  logic            clk_vga,
    input  logic            rst_n,
    input  fb_pkg::raster_t raster,
    input  fb_pkg::pixel_t  rd_data,
    output logic [AW-1:0]   rd_addr,
    output fb_pkg::pixel_t  rgb_out,
    output logic            hsync_out,
    output logic            vsync_out,
    output logic            blank_out,
    output logic            odd_line_out
);

    // Control bits that ride along with the memory read
    typedef struct packed {
        logic in_window;
        logic visible;
        logic hsync;
        logic vsync;
        logic odd_line;
    } ctl_t;

    // Idle value matching counts at zero
    localparam ctl_t CTL_RESET = '{in_window: 1'b0, visible: 1'b1, hsync: 1'b1,
                                   vsync: 1'b1, odd_line: 1'b0};

    ctl_t ctl_q [2];                    // Stage 1 address, stage 2 memory read

    // ------------------------------------------------------------------------
    // Stage 1 read address
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_vga) begin
        rd_addr <= AW'(raster.win_y * SRC_W + raster.win_x);
    end

    // Delay line for sync and blank, two stages here plus the output register
    always_ff @(posedge clk_vga) begin
        if (!rst_n) begin
            ctl_q[0] <= CTL_RESET;
            ctl_q[1] <= CTL_RESET;
        end else begin
            ctl_q[0].in_window <= raster.in_window;
            ctl_q[0].visible   <= raster.visible;
            ctl_q[0].hsync     <= raster.hsync;
            ctl_q[0].vsync     <= raster.vsync;
            ctl_q[0].odd_line  <= raster.odd_line;
            ctl_q[1]           <= ctl_q[0];     // Waits for memory data
        end
    end

    // ------------------------------------------------------------------------
    // Stage 3 output register
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_vga) begin
        if (!rst_n) begin
            rgb_out      <= '0;
            hsync_out    <= 1'b1;
            vsync_out    <= 1'b1;
            blank_out    <= 1'b0;
            odd_line_out <= 1'b0;
        end else begin
            // Black outside the picture and during blanking
            rgb_out      <= (ctl_q[1].in_window && ctl_q[1].visible) ? rd_data : '0;
            hsync_out    <= ctl_q[1].hsync;
            vsync_out    <= ctl_q[1].vsync;
            blank_out    <= !ctl_q[1].visible;
            odd_line_out <= ctl_q[1].odd_line;
        end
    end

endmodule

// ==== source/frame_store.sv ====
module frame_store #(
    parameter int  SRC_W = 320,
    parameter int  SRC_H = 240,
    localparam int AW    = $clog2(SRC_W * SRC_H)
) (
    input  logic              clk_vga,
    input  logic [1:0]        wr_en,
    input  fb_pkg::wr_pixel_t pix,
    input  logic              show_sel,
    input  logic [AW-1:0]     rd_addr,
    output fb_pkg::pixel_t    rd_data
);

    localparam int DEPTH = SRC_W * SRC_H;

    // Two frame memories, same address map
    fb_pkg::pixel_t mem [2][DEPTH];
    fb_pkg::pixel_t rd_q [2];           // Registered read of each memory
    logic [AW-1:0]  wr_addr;

    // Row major layout
    assign wr_addr = AW'(pix.y * SRC_W + pix.x);

    // ------------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_vga) begin
        for (int i = 0; i < 2; i++) begin
            if (wr_en[i]) begin
                mem[i][wr_addr] <= pix.rgb;     // Visible one clock after strobe
            end
        end
    end

    // ------------------------------------------------------------------------
    // Read port
    // ------------------------------------------------------------------------

    // Both memories read every cycle at the same address
    always_ff @(posedge clk_vga) begin
        for (int i = 0; i < 2; i++) begin
            rd_q[i] <= mem[i][rd_addr];
        end
    end

    // Select after the register so a swap needs no extra read cycle
    assign rd_data = show_sel ? rd_q[1] : rd_q[0];

    // Source must stay inside the frame it declares
    a_wr_in_range: assert property (@(posedge clk_vga)
        (wr_en != 2'b00) |-> (int'(pix.x) < SRC_W) && (int'(pix.y) < SRC_H));

endmodule

// ==== source/buffer_arbiter.sv ====
module buffer_arbiter (
    input  logic       clk_vga,
    input  logic       rst_n,
    input  logic       pix_valid,
    input  logic       vblank_in,
    input  logic       disable_db,
    input  logic       frame_end,
    output logic [1:0] wr_en,
    output logic       show_sel,
    output logic       buffer_using
);

    fb_pkg::buf_state_t state_q [2];    // One state per frame memory
    fb_pkg::buf_state_t state_d [2];
    logic               vblank_q;
    logic               frame_start;    // Source leaves blanking
    logic               frame_done;     // Source enters blanking
    logic               any_filling;
    logic               any_ready;

    // Edge detect of the source blanking level
    always_ff @(posedge clk_vga) begin
        if (!rst_n) begin
            vblank_q <= 1'b1;           // Idle source sits in blanking
        end else begin
            vblank_q <= vblank_in;
        end
    end

    assign frame_start = vblank_q && !vblank_in;
    assign frame_done  = !vblank_q && vblank_in;

    assign any_filling = (state_q[0] == fb_pkg::BUF_FILLING) ||
                         (state_q[1] == fb_pkg::BUF_FILLING);
    assign any_ready   = (state_q[0] == fb_pkg::BUF_READY) ||
                         (state_q[1] == fb_pkg::BUF_READY);

    // ------------------------------------------------------------------------
    // Buffer state machine
    // ------------------------------------------------------------------------

    always_comb begin
        state_d = state_q;
        if (!disable_db) begin                      // Frozen in single buffer mode
            if (frame_done) begin
                for (int i = 0; i < 2; i++) begin
                    if (state_d[i] == fb_pkg::BUF_FILLING) state_d[i] = fb_pkg::BUF_READY;
                end
            end
            // Claim a free buffer, buffer 0 wins a tie
            if (frame_start && !any_filling) begin
                if (state_d[0] == fb_pkg::BUF_FREE) begin
                    state_d[0] = fb_pkg::BUF_FILLING;
                end else if (state_d[1] == fb_pkg::BUF_FREE) begin
                    state_d[1] = fb_pkg::BUF_FILLING;
                end
            end
            // Swap only at the end of an output frame so nothing tears
            if (frame_end && any_ready) begin
                for (int i = 0; i < 2; i++) begin
                    if (state_d[i] == fb_pkg::BUF_SHOWN) begin
                        state_d[i] = fb_pkg::BUF_FREE;  // Old picture released
                    end else if (state_d[i] == fb_pkg::BUF_READY) begin
                        state_d[i] = fb_pkg::BUF_SHOWN;
                    end
                end
            end
        end
    end

    always_ff @(posedge clk_vga) begin
        if (!rst_n) begin
            state_q[0] <= fb_pkg::BUF_SHOWN;
            state_q[1] <= fb_pkg::BUF_FREE;
        end else begin
            state_q <= state_d;
        end
    end

    assign show_sel     = (state_q[1] == fb_pkg::BUF_SHOWN);
    assign buffer_using = show_sel;

    // Write steering, strobes with no filling buffer are lost
    always_comb begin
        wr_en = 2'b00;
        if (pix_valid) begin
            if (disable_db) begin
                wr_en[show_sel] = 1'b1;             // Straight into the shown picture
            end else begin
                for (int i = 0; i < 2; i++) begin
                    wr_en[i] = (state_q[i] == fb_pkg::BUF_FILLING);
                end
            end
        end
    end

    a_one_shown: assert property (@(posedge clk_vga) disable iff (!rst_n)
        !(state_q[0] == fb_pkg::BUF_SHOWN && state_q[1] == fb_pkg::BUF_SHOWN));
    a_one_filling: assert property (@(posedge clk_vga) disable iff (!rst_n)
        !(state_q[0] == fb_pkg::BUF_FILLING && state_q[1] == fb_pkg::BUF_FILLING));
    a_wr_onehot: assert property (@(posedge clk_vga) disable iff (!rst_n)
        $onehot0(wr_en));

endmodule

// ==== source/raster_timer.sv ====
module raster_timer #(
    parameter int              SRC_W  = 320,
    parameter int              SRC_H  = 240,
    parameter int              SCALE  = 2,
    parameter fb_pkg::timing_t TIMING = fb_pkg::VGA_640X480
) (
    input  logic            clk_vga,
    input  logic            rst_n,
    output fb_pkg::raster_t raster,
    output logic            frame_end
);

    // Scaled picture size on screen
    localparam int H_LEN   = SRC_W * SCALE;
    localparam int V_LEN   = SRC_H * SCALE;
    // Centre the picture inside the active area
    localparam int H_START = (int'(TIMING.h_active) + 1 - H_LEN) / 2;
    localparam int V_START = (int'(TIMING.v_active) + 1 - V_LEN) / 2;

    localparam logic [10:0] H_BEG = 11'(H_START);
    localparam logic [10:0] H_END = 11'(H_START + H_LEN);   // First column past window
    localparam logic [10:0] V_BEG = 11'(V_START);
    localparam logic [10:0] V_END = 11'(V_START + V_LEN);

    // Scale counter width, at least one bit
    localparam int             SCW     = (SCALE > 1) ? $clog2(SCALE) : 1;
    localparam logic [SCW-1:0] SC_LAST = SCW'(SCALE - 1);

    logic [10:0]    hcnt;           // Screen column
    logic [10:0]    vcnt;           // Screen line
    logic [10:0]    h_next;
    logic [10:0]    v_next;
    logic           h_wrap;         // Last column of the line
    logic           in_win_h;
    logic           in_win_v;
    logic [9:0]     win_x;
    logic [9:0]     win_y;
    logic [SCW-1:0] h_sc;           // Columns spent on current source pixel
    logic [SCW-1:0] v_sc;           // Lines spent on current source line

    // ------------------------------------------------------------------------
    // Screen counters
    // ------------------------------------------------------------------------

    assign h_wrap = (hcnt == TIMING.h_total);
    assign h_next = h_wrap ? 11'd0 : hcnt + 11'd1;
    assign v_next = !h_wrap ? vcnt :
                    (vcnt == TIMING.v_total) ? 11'd0 : vcnt + 11'd1;   // Step at line wrap

    always_ff @(posedge clk_vga) begin
        if (!rst_n) begin
            hcnt <= '0;
            vcnt <= '0;
        end else begin
            hcnt <= h_next;
            vcnt <= v_next;
        end
    end

    assign in_win_h = (hcnt >= H_BEG) && (hcnt < H_END);
    assign in_win_v = (vcnt >= V_BEG) && (vcnt < V_END);

    // ------------------------------------------------------------------------
    // Window position with integer upscale
    // ------------------------------------------------------------------------

    // Counts are set up so they match hcnt in the same cycle
    always_ff @(posedge clk_vga) begin
        if (!rst_n) begin
            win_x <= '0;
            h_sc  <= '0;
        end else if (h_next == H_BEG) begin
            win_x <= '0;                            // Window starts next column
            h_sc  <= '0;
        end else if (in_win_h) begin
            if (h_sc == SC_LAST) begin
                win_x <= win_x + 10'd1;             // Next source pixel
                h_sc  <= '0;
            end else begin
                h_sc  <= h_sc + 1'b1;               // Repeat same pixel
            end
        end
    end

    // Same rule vertically, stepped once per line
    always_ff @(posedge clk_vga) begin
        if (!rst_n) begin
            win_y <= '0;
            v_sc  <= '0;
        end else if (h_wrap) begin
            if (v_next == V_BEG) begin
                win_y <= '0;
                v_sc  <= '0;
            end else if (in_win_v) begin
                if (v_sc == SC_LAST) begin
                    win_y <= win_y + 10'd1;
                    v_sc  <= '0;
                end else begin
                    v_sc  <= v_sc + 1'b1;
                end
            end
        end
    end

    // Raster for the current cycle
    always_comb begin
        raster.win_x     = win_x;
        raster.win_y     = win_y;
        raster.in_window = in_win_h && in_win_v;
        raster.visible   = (hcnt <= TIMING.h_active) && (vcnt <= TIMING.v_active);
        raster.hsync     = !((hcnt > TIMING.h_sync_start) && (hcnt <= TIMING.h_sync_end));
        raster.vsync     = !((vcnt > TIMING.v_sync_start) && (vcnt <= TIMING.v_sync_end));
        raster.odd_line  = vcnt[0];
    end

    assign frame_end = h_wrap && (vcnt == TIMING.v_total);     // Last clock of the frame

    // Column count must wrap at the line total
    a_hcnt_range: assert property (@(posedge clk_vga) disable iff (!rst_n)
        hcnt <= TIMING.h_total);

endmodule

// ==== source/fb_pkg.sv ====
package fb_pkg;

    // Pixel format shared by the write port, the memories and the output
    localparam int PIXEL_W = 8;

    typedef logic [PIXEL_W-1:0] pixel_t;

    // ------------------------------------------------------------------------
    // Display timing
    // ------------------------------------------------------------------------

    // Every field is the last count index of its region (modeline value - 1)
    typedef struct packed {
        logic [10:0] h_active;      // Last visible column
        logic [10:0] h_sync_start;  // HSYNC low after this column
        logic [10:0] h_sync_end;    // Last column of HSYNC pulse
        logic [10:0] h_total;       // Last column of the line
        logic [10:0] v_active;      // Last visible line
        logic [10:0] v_sync_start;
        logic [10:0] v_sync_end;
        logic [10:0] v_total;       // Last line of the frame
    } timing_t;

    // 640x480 at 60 Hz, 25.175 MHz pixel clock
    localparam timing_t VGA_640X480 = '{
        h_active:     11'd639,
        h_sync_start: 11'd655,
        h_sync_end:   11'd751,
        h_total:      11'd799,
        v_active:     11'd479,
        v_sync_start: 11'd489,
        v_sync_end:   11'd491,
        v_total:      11'd524
    };

    // Raster position and video control for the current clock
    typedef struct packed {
        logic [9:0] win_x;          // Source column inside the window
        logic [9:0] win_y;          // Source line inside the window
        logic       in_window;      // Beam inside the scaled picture
        logic       visible;        // Beam inside the active area
        logic       hsync;          // Active low
        logic       vsync;          // Active low
        logic       odd_line;
    } raster_t;

    // Life cycle of one frame memory
    typedef enum logic [1:0] {
        BUF_FREE    = 2'd0,         // Nothing useful stored
        BUF_FILLING = 2'd1,         // Source is writing into it
        BUF_READY   = 2'd2,         // Complete frame waiting for display
        BUF_SHOWN   = 2'd3          // Being scanned out
    } buf_state_t;

    // One incoming pixel with its position
    typedef struct packed {
        logic [9:0] x;
        logic [9:0] y;
        pixel_t     rgb;
    } wr_pixel_t;

endpackage
